//--- design/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic field types

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;
    typedef logic [3:0]  id_t;

    // Address hash for load/store alias detection
    localparam int HASH_W = 8;
    typedef logic [HASH_W-1:0] addr_hash_t;

    ////////////////////////////////////////////////////////////////////////////
    // Entry and bus request records

    // Request as accepted from the issue side
    typedef struct packed {
        addr_t addr;
        be_t   be;
        data_t data;
        id_t   id;
        logic  load;
    } lsq_entry_t;

    // Transaction handed to the Wishbone master
    typedef struct packed {
        addr_t addr;
        be_t   be;
        data_t data;
        logic  we;
        id_t   id;
    } bus_req_t;

    // XOR fold of the word address into HASH_W bits
    // Equal addresses always give equal hashes, so aliasing is conservative
    function automatic addr_hash_t hash_addr(input addr_t addr);
        logic [31:0] word;
        addr_hash_t  fold;
        word = {2'b00, addr[31:2]};
        fold = '0;
        for (int i = 0; i < 32; i += HASH_W) begin
            fold = fold ^ word[i +: HASH_W];
        end
        return fold;
    endfunction

endpackage

`default_nettype wire

//--- design/lsq_entry_if.sv
`timescale 1ns/1ns
`default_nettype none

interface lsq_entry_if
    import lsq_pkg::*;
#(
    parameter int SQ_DEPTH = 4
) ();

    // Accepted request, shared by both queues
    lsq_entry_t          payload;
    // One-cycle push strobes, at most one high
    logic                load_push;
    logic                store_push;
    // Store slots that may alias the pushed address
    logic [SQ_DEPTH-1:0] conflicts;

    // Request steering side
    modport source (
        output payload,
        output load_push,
        output store_push
    );

    // Queue side
    // Store queue drives conflicts, load queue only samples it
    modport sink (
        input  payload,
        input  load_push,
        input  store_push,
        output conflicts
    );

endinterface

`default_nettype wire

//--- design/load_queue.sv
`timescale 1ns/1ns
`default_nettype none

module load_queue
    import lsq_pkg::*;
#(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    lsq_entry_if.sink                entry,
    output lsq_entry_t               head,
    output logic                     head_valid,
    output logic [SQ_DEPTH-1:0]      head_conflicts,
    output logic                     full,
    input  wire logic                pop,
    input  wire logic [SQ_DEPTH-1:0] store_done_mask
);

    localparam int PTR_W = (LQ_DEPTH > 1) ? $clog2(LQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(LQ_DEPTH + 1);

    lsq_entry_t          slots [LQ_DEPTH];
    logic [SQ_DEPTH-1:0] masks [LQ_DEPTH];
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W-1:0]    wr_ptr;
    logic [CNT_W-1:0]    count;
    logic                push;

    // Top level only pushes when not full
    assign push = entry.load_push;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(LQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(LQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Load payload
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= entry.payload;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Store conflict masks

    // Bits drop as the matching store slots go to the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                masks[i] <= '0;
            end
        end else begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                masks[i] <= masks[i] & ~store_done_mask;
            end
            // Store leaving this same cycle is already safe
            if (push) begin
                masks[wr_ptr] <= entry.conflicts & ~store_done_mask;
            end
        end
    end

    // Oldest load and its outstanding stores
    assign head           = slots[rd_ptr];
    assign head_conflicts = masks[rd_ptr];
    assign head_valid     = (count != '0);
    assign full           = (count == CNT_W'(LQ_DEPTH));

endmodule

`default_nettype wire

//--- design/store_queue.sv
`timescale 1ns/1ns
`default_nettype none

module store_queue
    import lsq_pkg::*;
#(
    parameter int SQ_DEPTH = 4
) (
    input  wire logic           clk,
    input  wire logic           rst_n,
    lsq_entry_if.sink           entry,
    output lsq_entry_t          head,
    output logic                head_valid,
    output logic                full,
    output logic [SQ_DEPTH-1:0] store_done_mask,
    input  wire logic           pop
);

    localparam int PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;

    lsq_entry_t          slots  [SQ_DEPTH];
    addr_hash_t          hashes [SQ_DEPTH];
    logic [SQ_DEPTH-1:0] valid;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W-1:0]    wr_ptr;
    addr_hash_t          push_hash;
    logic                push;

    assign push      = entry.store_push;
    assign push_hash = hash_addr(entry.payload.addr);

    ////////////////////////////////////////////////////////////////////////////
    // Slot tracking

    // In-order ring, so the write slot is busy only when every slot is
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            valid  <= '0;
        end else begin
            if (pop) begin
                valid[rd_ptr] <= 1'b0;
                rd_ptr        <= (rd_ptr == PTR_W'(SQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push) begin
                valid[wr_ptr] <= 1'b1;
                wr_ptr        <= (wr_ptr == PTR_W'(SQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
        end
    end

    // Store payload and its hash
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr]  <= entry.payload;
            hashes[wr_ptr] <= push_hash;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Alias detection for the incoming entry

    // Every live store with a matching hash counts as a possible alias
    // Only sampled by the load queue on a load push
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            entry.conflicts[i] = valid[i] && (hashes[i] == push_hash);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Head and issue notification

    // One-hot of the slot handed to the bus this cycle
    always_comb begin
        store_done_mask = '0;
        if (pop) begin
            store_done_mask[rd_ptr] = 1'b1;
        end
    end

    assign head       = slots[rd_ptr];
    assign head_valid = valid[rd_ptr];
    assign full       = valid[wr_ptr];

endmodule

`default_nettype wire

//--- design/release_counter.sv
`timescale 1ns/1ns
`default_nettype none

module release_counter #(
    parameter int SQ_DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic retire_store,
    input  wire logic store_issued,
    output logic      released
);

    // Never more retired than queued, so SQ_DEPTH is the ceiling
    localparam int CNT_W = $clog2(SQ_DEPTH + 1);

    logic [CNT_W-1:0] count;

    // Retire adds one, issue removes one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({retire_store, store_issued})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest queued store is retired
    assign released = (count != '0);

endmodule

`default_nettype wire

//--- design/wb_master_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module wb_master_fsm
    import lsq_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire bus_req_t req,
    input  wire logic     req_valid,
    output logic          req_accept,
    input  wire logic     wb_ack,
    input  wire data_t    wb_dat_r,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output addr_t         wb_adr,
    output data_t         wb_dat_w,
    output be_t           wb_sel,
    output logic          load_done,
    output id_t           load_id,
    output data_t         load_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESULT
    } state_t;

    state_t   state;
    bus_req_t cur;
    data_t    rd_data;

    // Only one transaction in flight
    assign req_accept = req_valid && (state == ST_IDLE);

    ////////////////////////////////////////////////////////////////////////////
    // State sequencing

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_accept) begin
                        state <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    // Writes finish on ack, reads report one cycle later
                    if (wb_ack) begin
                        state <= cur.we ? ST_IDLE : ST_RESULT;
                    end
                end
                ST_RESULT: state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Transaction held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (req_accept) begin
            cur <= req;
        end
        if ((state == ST_BUS) && wb_ack && !cur.we) begin
            rd_data <= wb_dat_r;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus and result outputs

    // Strobes fall with the state change after ack
    assign wb_cyc   = (state == ST_BUS);
    assign wb_stb   = (state == ST_BUS);
    assign wb_we    = cur.we;
    assign wb_adr   = cur.addr;
    assign wb_dat_w = cur.data;
    assign wb_sel   = cur.be;

    assign load_done = (state == ST_RESULT);
    assign load_id   = cur.id;
    assign load_data = rd_data;

endmodule

`default_nettype wire

//--- design/load_store_queue.sv
`timescale 1ns/1ns
`default_nettype none

module load_store_queue
    import lsq_pkg::*;
#(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    // Issue side request
    input  wire logic  req_valid,
    output logic       req_ready,
    input  wire logic  req_load,
    input  wire addr_t req_addr,
    input  wire be_t   req_be,
    input  wire data_t req_data,
    input  wire id_t   req_id,
    input  wire logic  retire_store,
    // Wishbone classic master
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output addr_t      wb_adr,
    output data_t      wb_dat_w,
    output be_t        wb_sel,
    input  wire logic  wb_ack,
    input  wire data_t wb_dat_r,
    // Load results
    output logic       load_done,
    output id_t        load_id,
    output data_t      load_data
);

    lsq_entry_t          lq_head;
    logic                lq_head_valid;
    logic [SQ_DEPTH-1:0] lq_head_conflicts;
    logic                lq_full;
    logic                lq_pop;
    lsq_entry_t          sq_head;
    logic                sq_head_valid;
    logic                sq_full;
    logic                sq_pop;
    logic [SQ_DEPTH-1:0] store_done_mask;
    logic                released;
    logic                req_fire;
    logic                load_sel;
    logic                store_sel;
    bus_req_t            bus_req;
    logic                bus_valid;
    logic                bus_accept;

    lsq_entry_if #(.SQ_DEPTH(SQ_DEPTH)) entry_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Request steering

    // Back-pressure only from the queue the entry targets
    assign req_ready = req_load ? !lq_full : !sq_full;
    assign req_fire  = req_valid && req_ready;

    assign entry_bus.payload.addr = req_addr;
    assign entry_bus.payload.be   = req_be;
    assign entry_bus.payload.data = req_data;
    assign entry_bus.payload.id   = req_id;
    assign entry_bus.payload.load = req_load;
    assign entry_bus.load_push    = req_fire && req_load;
    assign entry_bus.store_push   = req_fire && !req_load;

    load_queue #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) u_load_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .entry           (entry_bus),
        .head            (lq_head),
        .head_valid      (lq_head_valid),
        .head_conflicts  (lq_head_conflicts),
        .full            (lq_full),
        .pop             (lq_pop),
        .store_done_mask (store_done_mask)
    );

    store_queue #(.SQ_DEPTH(SQ_DEPTH)) u_store_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .entry           (entry_bus),
        .head            (sq_head),
        .head_valid      (sq_head_valid),
        .full            (sq_full),
        .store_done_mask (store_done_mask),
        .pop             (sq_pop)
    );

    release_counter #(.SQ_DEPTH(SQ_DEPTH)) u_release_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .retire_store (retire_store),
        .store_issued (sq_pop),
        .released     (released)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Load-over-store arbitration

    // A load waits only while an older aliasing store is still queued
    assign load_sel  = lq_head_valid && (lq_head_conflicts == '0);
    assign store_sel = !load_sel && sq_head_valid && released;
    assign bus_valid = load_sel || store_sel;

    // Loads read the full word
    assign bus_req.addr = load_sel ? lq_head.addr : sq_head.addr;
    assign bus_req.be   = load_sel ? '1 : sq_head.be;
    assign bus_req.data = sq_head.data;
    assign bus_req.we   = !load_sel;
    assign bus_req.id   = load_sel ? lq_head.id : sq_head.id;

    // Master accept dequeues whichever head was offered
    assign lq_pop = bus_accept && load_sel;
    assign sq_pop = bus_accept && store_sel;

    wb_master_fsm u_wb_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (bus_req),
        .req_valid  (bus_valid),
        .req_accept (bus_accept),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_sel     (wb_sel),
        .load_done  (load_done),
        .load_id    (load_id),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

//--- bench/tb_lsq.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsq
    import lsq_pkg::*;
();

    localparam int    LQ_DEPTH   = 4;
    localparam int    SQ_DEPTH   = 4;
    localparam int    N_RANDOM   = 200;
    localparam int    N_BP_LOADS = 8;
    localparam addr_t BASE       = 32'h0000_4a00;

    // Stimulus modes
    localparam int M_IDLE   = 0;
    localparam int M_RANDOM = 1;
    localparam int M_DRAIN  = 2;
    localparam int M_FILL   = 3;
    localparam int M_PROBE  = 4;

    // Wait conditions
    localparam int C_SENT   = 0;
    localparam int C_IDLE   = 1;
    localparam int C_FILLED = 2;
    localparam int C_PROBED = 3;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_ready;
    logic  req_load;
    addr_t req_addr;
    be_t   req_be;
    data_t req_data;
    id_t   req_id;
    logic  retire_store;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    data_t wb_dat_w;
    be_t   wb_sel;
    logic  wb_ack;
    data_t wb_dat_r;
    logic  load_done;
    id_t   load_id;
    data_t load_data;

    integer      seed;
    int          mode;
    data_t       slave_mem [8];
    data_t       shadow [8];
    logic [31:0] exp_load_id [$];
    logic [31:0] exp_load_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] exp_st_be [$];
    int          loads_pushed;
    int          loads_finished;
    int          stores_pushed;
    int          stores_written;
    int          retires_given;
    int          store_target;
    int          load_target;
    logic        accepted;
    id_t         next_id;
    logic        slave_busy;
    int          ack_wait;
    // Bus outputs seen while waiting for ack
    logic        bus_hold;
    logic        held_we;
    addr_t       held_adr;
    data_t       held_dat;
    be_t         held_sel;

    load_store_queue #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_load     (req_load),
        .req_addr     (req_addr),
        .req_be       (req_be),
        .req_data     (req_data),
        .req_id       (req_id),
        .retire_store (retire_store),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r),
        .load_done    (load_done),
        .load_id      (load_id),
        .load_data    (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Initial memory word, a function of the full byte address
    function automatic data_t fill_word(input addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic addr_t word_addr(input int idx);
        return BASE + addr_t'(idx * 4);
    endfunction

    // Byte-lane write
    function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, actual, expected);
            stop_on_failure();
        end
    endtask

    function automatic logic phase_reached(input int which);
        case (which)
            C_SENT:   return (loads_pushed + stores_pushed) == N_RANDOM;
            C_IDLE:   return (retires_given == stores_pushed) && (stores_written == stores_pushed)
                             && (loads_finished == loads_pushed) && !wb_cyc;
            C_FILLED: return stores_pushed == store_target;
            C_PROBED: return (loads_pushed == load_target) && (loads_finished == loads_pushed);
            default:  return 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int which, input int limit, input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles waiting for %s", limit, what);
                stop_on_failure();
            end
        end while (!phase_reached(which));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Falling edge: Wishbone slave, then issue side stimulus

    task automatic answer_bus();
        int idx;
        idx = wb_adr[4:2];
        if (!rst_n) begin
            wb_ack     = 1'b0;
            slave_busy = 1'b0;
        end else if (wb_ack) begin
            // Read data valid only with ack
            wb_ack     = 1'b0;
            wb_dat_r   = ~wb_dat_r;
            slave_busy = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            // 0 to 3 wait states per cycle
            if (!slave_busy) begin
                slave_busy = 1'b1;
                ack_wait   = {$random(seed)} % 4;
            end
            if (ack_wait == 0) begin
                if (wb_we) begin
                    slave_mem[idx] = merge_bytes(slave_mem[idx], wb_dat_w, wb_sel);
                end else begin
                    wb_dat_r = slave_mem[idx];
                end
                wb_ack = 1'b1;
            end else begin
                ack_wait--;
            end
        end
    endtask

    task automatic offer_request(input logic load, input int idx);
        req_valid = 1'b1;
        req_load  = load;
        req_addr  = word_addr(idx);
        req_id    = next_id;
        req_data  = $random(seed);
        // Random enables on loads as well
        req_be    = be_t'($random(seed));
        if (req_be == 4'h0) begin
            req_be = 4'hf;
        end
        next_id++;
    endtask

    task automatic drive_stimulus();
        retire_store = 1'b0;
        // Retire only stores already pushed
        if ((mode == M_RANDOM) && (retires_given < stores_pushed)) begin
            retire_store = ({$random(seed)} % 3) == 0;
        end else if ((mode == M_DRAIN) && (retires_given < stores_pushed)) begin
            retire_store = 1'b1;
        end
        // Offered request stays until the handshake
        if (!(req_valid && !accepted)) begin
            accepted  = 1'b0;
            req_valid = 1'b0;
            req_load  = 1'b0;
            case (mode)
                M_RANDOM: begin
                    if ((loads_pushed + stores_pushed < N_RANDOM) && ({$random(seed)} % 4 != 0)) begin
                        offer_request({$random(seed)} % 2, {$random(seed)} % 8);
                    end
                end
                M_FILL: begin
                    if (stores_pushed < store_target) begin
                        offer_request(1'b0, {$random(seed)} % 4);
                    end
                end
                // Loads only to words no queued store touches
                M_PROBE: begin
                    if ((loads_pushed < load_target) && ({$random(seed)} % 2 == 0)) begin
                        offer_request(1'b1, 4 + {$random(seed)} % 4);
                    end
                end
                default: ;
            endcase
        end
    endtask

    always @(negedge clk) begin
        answer_bus();
        drive_stimulus();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Rising edge: reference model and checks

    task automatic watch_bus();
        logic [31:0] exp;
        if (bus_hold) begin
            check_value("wb_cyc", wb_cyc, 1'b1);
            check_value("wb_we", wb_we, held_we);
            check_value("wb_adr", wb_adr, held_adr);
            check_value("wb_dat_w", wb_dat_w, held_dat);
            check_value("wb_sel", wb_sel, held_sel);
        end
        check_value("wb_stb", wb_stb, wb_cyc);
        if (wb_cyc && wb_ack) begin
            if (wb_we) begin
                if (exp_st_addr.size() == 0) begin
                    $display("Store write seen on the bus with no store outstanding");
                    stop_on_failure();
                end
                // Retire pulse for this store given at an earlier edge
                check_value("store_retired", retires_given > stores_written, 1'b1);
                exp = exp_st_addr.pop_front();
                check_value("wb_adr", wb_adr, exp);
                exp = exp_st_data.pop_front();
                check_value("wb_dat_w", wb_dat_w, exp);
                exp = exp_st_be.pop_front();
                check_value("wb_sel", wb_sel, exp);
                stores_written++;
            end else begin
                check_value("wb_sel", wb_sel, 4'hf);
            end
        end
        bus_hold = wb_cyc && !wb_ack;
        held_we  = wb_we;
        held_adr = wb_adr;
        held_dat = wb_dat_w;
        held_sel = wb_sel;
    endtask

    task automatic watch_requests();
        int idx;
        idx = req_addr[4:2];
        if (req_valid && req_ready) begin
            accepted = 1'b1;
            if (req_load) begin
                // Expected word is the image at push time
                exp_load_id.push_back(req_id);
                exp_load_data.push_back(shadow[idx]);
                loads_pushed++;
            end else begin
                shadow[idx] = merge_bytes(shadow[idx], req_data, req_be);
                exp_st_addr.push_back(req_addr);
                exp_st_data.push_back(req_data);
                exp_st_be.push_back(req_be);
                stores_pushed++;
            end
        end
        if (retire_store) begin
            retires_given++;
        end
        // Full store queue blocks stores
        if ((mode == M_PROBE) && !req_valid && !req_load) begin
            check_value("req_ready", req_ready, 1'b0);
        end
    endtask

    task automatic watch_results();
        logic [31:0] exp;
        if (load_done) begin
            if (exp_load_id.size() == 0) begin
                $display("load_done pulsed with no load outstanding");
                stop_on_failure();
            end
            exp = exp_load_id.pop_front();
            check_value("load_id", load_id, exp);
            exp = exp_load_data.pop_front();
            check_value("load_data", load_data, exp);
            loads_finished++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            watch_bus();
            watch_requests();
            watch_results();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        seed           = 98006;
        mode           = M_IDLE;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_load       = 1'b0;
        req_addr       = '0;
        req_be         = '0;
        req_data       = '0;
        req_id         = '0;
        retire_store   = 1'b0;
        wb_ack         = 1'b0;
        wb_dat_r       = '0;
        loads_pushed   = 0;
        loads_finished = 0;
        stores_pushed  = 0;
        stores_written = 0;
        retires_given  = 0;
        store_target   = 0;
        load_target    = 0;
        accepted       = 1'b0;
        next_id        = '0;
        slave_busy     = 1'b0;
        ack_wait       = 0;
        bus_hold       = 1'b0;
        for (int i = 0; i < 8; i++) begin
            slave_mem[i] = fill_word(word_addr(i));
            shadow[i]    = fill_word(word_addr(i));
        end

        repeat (4) @(posedge clk);
        check_value("wb_cyc", wb_cyc, 1'b0);
        check_value("wb_stb", wb_stb, 1'b0);
        check_value("load_done", load_done, 1'b0);
        check_value("req_ready", req_ready, 1'b1);
        @(negedge clk);
        rst_n <= 1'b1;

        // Mixed traffic with frequent aliasing
        mode <= M_RANDOM;
        wait_until(C_SENT, 20000, "random requests to be accepted");
        mode <= M_DRAIN;
        wait_until(C_IDLE, 5000, "the queues to drain after random traffic");

        // Fill the store queue with nothing retired
        store_target <= stores_pushed + SQ_DEPTH;
        mode         <= M_FILL;
        wait_until(C_FILLED, 1000, "the store queue to fill");
        load_target <= loads_pushed + N_BP_LOADS;
        mode        <= M_PROBE;
        wait_until(C_PROBED, 2000, "loads to complete past a full store queue");
        check_value("stores_written", stores_written, stores_pushed - SQ_DEPTH);

        mode <= M_DRAIN;
        wait_until(C_IDLE, 2000, "the final drain");
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("slave_mem[%0d]", i), slave_mem[i], shadow[i]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/lsq_pkg.sv
design/lsq_entry_if.sv
design/load_queue.sv
design/store_queue.sv
design/release_counter.sv
design/wb_master_fsm.sv
design/load_store_queue.sv
bench/tb_lsq.sv
